// ==== src/uart_pkg.sv ====
package uart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DATA_W = 32;
    // Byte address; the word index is addr[31:2].
    localparam int ADDR_W = 32;
    localparam int BE_W   = 4;

    // Clocks-per-bit divisor width.
    localparam int CBP_W  = 16;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int REG_CBP    = 0;
    localparam int REG_STOP   = 1;
    // Read-only, loaded by the receiver.
    localparam int REG_RXDATA = 2;
    localparam int REG_TXDATA = 3;
    localparam int REG_CTRL   = 4;

    // Control and status bits of word 4.
    localparam int CTRL_TX_EN   = 0;
    localparam int CTRL_RX_DONE = 1;
    localparam int CTRL_TX_DONE = 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stop-bit select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int STOP_W = 2;

    // Only this code gives one stop bit, any other gives two.
    localparam logic [STOP_W-1:0] STOP_ONE = 2'b00;

endpackage

// ==== src/uart_regs.sv ====
`timescale 1ns/10ps

module uart_regs import uart_pkg::*; #(
    parameter int                  NUM_REGS    = 5,
    parameter logic [NUM_REGS-1:0] ALLOW_WRITE = 5'b11011
) (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic              write_i,
    input  logic [BE_W-1:0]   be_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o,

    input  logic [7:0]        rx_data_i,
    input  logic              rx_done_i,
    input  logic              tx_done_i,

    output logic [CBP_W-1:0]  cbp_o,
    output logic [STOP_W-1:0] stop_bits_o,
    output logic [7:0]        tx_data_o,
    output logic              tx_en_o
);

    logic [DATA_W-1:0] regs_q [NUM_REGS];
    logic [DATA_W-1:0] regs_d [NUM_REGS];
    logic [ADDR_W-3:0] word_idx;
    logic [NUM_REGS-1:0] sel;
    logic [NUM_REGS-1:0] wr_en;

    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_w,
        input logic [DATA_W-1:0] new_w,
        input logic [BE_W-1:0]   be
    );
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign word_idx = addr_i[ADDR_W-1:2];

    // An index past the last word matches no select line.
    for (genvar i = 0; i < NUM_REGS; i++) begin : g_sel
        assign sel[i]   = (word_idx == (ADDR_W-2)'(i));
        assign wr_en[i] = write_i && sel[i] && ALLOW_WRITE[i];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int w = 0; w < NUM_REGS; w++) begin
            regs_d[w] = wr_en[w] ? merge_bytes(regs_q[w], wdata_i, be_i) : regs_q[w];
        end

        // Done pulses override a bus write to the same bits.
        if (rx_done_i) begin
            regs_d[REG_RXDATA] = {{(DATA_W-8){1'b0}}, rx_data_i};
            regs_d[REG_CTRL][CTRL_RX_DONE] = 1'b1;
        end
        if (tx_done_i) begin
            regs_d[REG_CTRL][CTRL_TX_EN]   = 1'b0;
            regs_d[REG_CTRL][CTRL_TX_DONE] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int w = 0; w < NUM_REGS; w++) begin
                regs_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < NUM_REGS; w++) begin
                regs_q[w] <= regs_d[w];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read mux and outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Zero when no word is selected.
    always_comb begin
        rdata_o = '0;
        for (int w = 0; w < NUM_REGS; w++) begin
            if (sel[w]) begin
                rdata_o = regs_q[w];
            end
        end
    end

    assign cbp_o       = regs_q[REG_CBP][CBP_W-1:0];
    assign stop_bits_o = regs_q[REG_STOP][STOP_W-1:0];
    assign tx_data_o   = regs_q[REG_TXDATA][7:0];
    assign tx_en_o     = regs_q[REG_CTRL][CTRL_TX_EN];

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx import uart_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic [CBP_W-1:0]  cbp_i,
    input  logic [STOP_W-1:0] stop_bits_i,
    input  logic [7:0]        data_i,
    input  logic              en_i,
    output logic              tx_o,
    output logic              done_o
);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_START = 3'd1;
    localparam logic [2:0] ST_DATA  = 3'd2;
    localparam logic [2:0] ST_STOP1 = 3'd3;
    localparam logic [2:0] ST_STOP2 = 3'd4;

    logic [2:0]       state_q;
    logic [CBP_W-1:0] cnt_q;
    logic [2:0]       bit_idx_q;
    logic             done_q;
    logic [CBP_W-1:0] cbp_q;
    logic [7:0]       shift_q;
    logic             two_stop_q;
    logic [CBP_W-1:0] cbp_eff;
    logic             start;
    logic             bit_end;

    // A zero divisor runs as one.
    assign cbp_eff = (cbp_i == '0) ? CBP_W'(1) : cbp_i;
    assign bit_end = (cnt_q == '0);

    // Hold off for the done cycle, while the enable is being cleared.
    assign start = (state_q == ST_IDLE) && en_i && !done_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state_q == ST_IDLE) begin
                if (start) begin
                    state_q <= ST_START;
                    cnt_q   <= cbp_eff - 1'b1;
                end
            end else if (!bit_end) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                cnt_q <= cbp_q - 1'b1;
                case (state_q)
                    ST_START: begin
                        state_q   <= ST_DATA;
                        bit_idx_q <= '0;
                    end
                    ST_DATA: begin
                        if (bit_idx_q == 3'd7) state_q <= ST_STOP1;
                        bit_idx_q <= bit_idx_q + 1'b1;
                    end
                    ST_STOP1: begin
                        state_q <= two_stop_q ? ST_STOP2 : ST_IDLE;
                        done_q  <= !two_stop_q;
                    end
                    default: begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Frame payload, latched at start.
    always_ff @(posedge clk_i) begin
        if (start) begin
            cbp_q      <= cbp_eff;
            shift_q    <= data_i;
            two_stop_q <= (stop_bits_i != STOP_ONE);
        end else if (state_q == ST_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign tx_o   = (state_q == ST_START) ? 1'b0 :
                    (state_q == ST_DATA)  ? shift_q[0] : 1'b1;
    assign done_o = done_q;

endmodule

// ==== src/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx import uart_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [CBP_W-1:0] cbp_i,
    input  logic             rx_i,
    output logic [7:0]       data_o,
    output logic             done_o
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

    logic             rx_meta_q;
    logic             rx_sync_q;
    logic [1:0]       state_q;
    logic [CBP_W-1:0] cnt_q;
    logic [2:0]       bit_idx_q;
    logic             done_q;
    logic [CBP_W-1:0] cbp_q;
    logic [7:0]       shift_q;
    logic [7:0]       data_q;
    logic [CBP_W-1:0] cbp_eff;
    logic [CBP_W-1:0] half_bit;
    logic             start_seen;
    logic             bit_end;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line synchronizer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Held at the idle level in reset so no false start is seen.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign cbp_eff    = (cbp_i == '0) ? CBP_W'(1) : cbp_i;
    assign half_bit   = cbp_eff >> 1;
    assign start_seen = (state_q == ST_IDLE) && !rx_sync_q;
    assign bit_end    = (cnt_q == '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state_q == ST_IDLE) begin
                if (start_seen) begin
                    // A one-cycle bit goes straight to the data bits.
                    if (half_bit == '0) begin
                        state_q   <= ST_DATA;
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                    end else begin
                        // Counted from the first low sample.
                        state_q <= ST_START;
                        cnt_q   <= half_bit - 1'b1;
                    end
                end
            end else if (!bit_end) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                cnt_q <= cbp_q - 1'b1;
                case (state_q)
                    ST_START: begin
                        // Line back high at mid start bit is a glitch.
                        state_q   <= rx_sync_q ? ST_IDLE : ST_DATA;
                        bit_idx_q <= '0;
                    end
                    ST_DATA: begin
                        if (bit_idx_q == 3'd7) state_q <= ST_STOP;
                        bit_idx_q <= bit_idx_q + 1'b1;
                    end
                    default: begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Bits arrive LSB first, so shift in from the top.
    always_ff @(posedge clk_i) begin
        if (start_seen) begin
            cbp_q <= cbp_eff;
        end
        if (state_q == ST_DATA && bit_end) begin
            shift_q <= {rx_sync_q, shift_q[7:1]};
        end
        if (state_q == ST_STOP && bit_end) begin
            data_q <= shift_q;
        end
    end

    assign data_o = data_q;
    assign done_o = done_q;

endmodule

// ==== src/uart_periph.sv ====
`timescale 1ns/10ps

module uart_periph import uart_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic              write_i,
    input  logic [BE_W-1:0]   be_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o,

    input  logic              rx_i,
    output logic              tx_o
);

    // Word 2 stays read-only.
    localparam int                  NUM_REGS    = 5;
    localparam logic [NUM_REGS-1:0] ALLOW_WRITE = 5'b11011;

    logic [CBP_W-1:0]  cbp;
    logic [STOP_W-1:0] stop_bits;
    logic [7:0]        tx_data;
    logic              tx_en;
    logic              tx_done;
    logic [7:0]        rx_data;
    logic              rx_done;

    uart_regs #(
        .NUM_REGS    (NUM_REGS),
        .ALLOW_WRITE (ALLOW_WRITE)
    ) u_regs (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .write_i     (write_i),
        .be_i        (be_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rdata_o     (rdata_o),
        .rx_data_i   (rx_data),
        .rx_done_i   (rx_done),
        .tx_done_i   (tx_done),
        .cbp_o       (cbp),
        .stop_bits_o (stop_bits),
        .tx_data_o   (tx_data),
        .tx_en_o     (tx_en)
    );

    uart_tx u_tx (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cbp_i       (cbp),
        .stop_bits_i (stop_bits),
        .data_i      (tx_data),
        .en_i        (tx_en),
        .tx_o        (tx_o),
        .done_o      (tx_done)
    );

    uart_rx u_rx (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cbp_i       (cbp),
        .rx_i        (rx_i),
        .data_o      (rx_data),
        .done_o      (rx_done)
    );

endmodule

// ==== sim/uart_periph_properties.sv ====
`timescale 1ns/10ps

module uart_periph_properties (
    input logic        clk_i,
    input logic        rst_i,
    input logic        tx_line_i,
    input logic [2:0]  tx_state_i,
    input logic        tx_en_i,
    input logic        tx_done_i,
    input logic        rx_done_i,
    input logic [31:0] rx_word_i
);

    localparam logic [2:0] TX_IDLE = 3'd0;

    // Idle line level holds until a frame is started.
    tx_idle_high: assert property (@(posedge clk_i) disable iff (rst_i)
        (tx_state_i == TX_IDLE) && (!tx_en_i || tx_done_i) |=> tx_line_i)
        else $error("tx_o left the idle level without a frame start");

    tx_done_single: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_done_i |=> !tx_done_i)
        else $error("transmitter done pulse longer than one cycle");

    tx_en_cleared: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_done_i |=> !tx_en_i)
        else $error("transmit enable still set after the done pulse");

    // Word 2 is loaded only by the receiver.
    rx_word_update: assert property (@(posedge clk_i) disable iff (rst_i)
        !$stable(rx_word_i) |-> $past(rx_done_i))
        else $error("received byte word changed without a receive done pulse");

endmodule

bind uart_periph uart_periph_properties u_props (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .tx_line_i  (tx_o),
    .tx_state_i (u_tx.state_q),
    .tx_en_i    (tx_en),
    .tx_done_i  (tx_done),
    .rx_done_i  (rx_done),
    .rx_word_i  (u_regs.regs_q[2])
);

// ==== sim/uart_periph_tb.sv ====
`timescale 1ns/10ps

module uart_periph_tb import uart_pkg::*; ();

    localparam int NUM_ROWS  = 8;
    localparam int NUM_WORDS = 5;

    logic              clk_i;
    logic              rst_i;
    logic              bus_write;
    logic [BE_W-1:0]   bus_be;
    logic [ADDR_W-1:0] bus_addr;
    logic [DATA_W-1:0] bus_wdata;
    logic [DATA_W-1:0] bus_rdata;
    logic              serial_line;

    // Divisor, stop select and byte for each frame.
    logic [CBP_W-1:0]  row_cbp  [NUM_ROWS] = '{16'd4, 16'd7, 16'd2, 16'd1,
                                               16'd0, 16'd16, 16'd9, 16'd12};
    logic [STOP_W-1:0] row_stop [NUM_ROWS] = '{2'd0, 2'd1, 2'd0, 2'd2,
                                               2'd3, 2'd0, 2'd1, 2'd0};
    logic [7:0]        row_byte [NUM_ROWS] = '{8'h55, 8'hA3, 8'h00, 8'hFF,
                                               8'h81, 8'h3C, 8'h7E, 8'hC9};

    int                errors;
    int                checks;
    int                frames_seen;
    int                cycle_count;
    logic              reset_done;
    logic [CBP_W-1:0]  cur_cbp;
    logic              cur_two_stop;
    logic [7:0]        cur_byte;
    logic [DATA_W-1:0] exp_regs [NUM_WORDS];
    logic [DATA_W-1:0] rd;

    // Serial line looped back into the receiver.
    uart_periph uut (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .write_i (bus_write),
        .be_i    (bus_be),
        .addr_i  (bus_addr),
        .wdata_i (bus_wdata),
        .rdata_o (bus_rdata),
        .rx_i    (serial_line),
        .tx_o    (serial_line)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [CBP_W-1:0] effective_cbp(input logic [CBP_W-1:0] cbp);
        return (cbp == '0) ? CBP_W'(1) : cbp;
    endfunction

    function automatic int timeout_cycles();
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += int'(effective_cbp(row_cbp[r])) * 11;
        end
        return 2 * total + 2000;
    endfunction

    function automatic logic [DATA_W-1:0] apply_enables(input logic [DATA_W-1:0] old_w,
                                                        input logic [DATA_W-1:0] new_w,
                                                        input logic [BE_W-1:0]   be);
        logic [DATA_W-1:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic write_word(input int idx, input logic [BE_W-1:0] be,
                              input logic [DATA_W-1:0] data);
        @(negedge clk_i);
        bus_write = 1'b1;
        bus_be    = be;
        bus_addr  = idx * 4;
        bus_wdata = data;
        @(negedge clk_i);
        bus_write = 1'b0;
        bus_be    = '0;
    endtask

    // Reads are combinational, so sample well inside the low phase.
    task automatic read_word(input int idx, output logic [DATA_W-1:0] data);
        @(negedge clk_i);
        bus_addr = idx * 4;
        #10;
        data = bus_rdata;
    endtask

    task automatic wait_for_flags();
        logic [DATA_W-1:0] status;
        status = '0;
        while (!(status[CTRL_RX_DONE] && status[CTRL_TX_DONE])) begin
            read_word(REG_CTRL, status);
        end
    endtask

    task automatic check_byte_enables(input int idx);
        logic [BE_W-1:0]   be_list [5];
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] value;
        be_list = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1111};
        for (int k = 0; k < 5; k++) begin
            data = 32'h8899AABB ^ (32'h01010101 * (idx * 5 + k + 1));
            write_word(idx, be_list[k], data);
            exp_regs[idx] = apply_enables(exp_regs[idx], data, be_list[k]);
            read_word(idx, value);
            check_value($sformatf("rdata word %0d", idx), value, exp_regs[idx]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial line checker
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Samples each bit on the falling clock edge nearest its center.
    initial begin : line_checker
        logic [7:0] rebuilt;
        wait (reset_done);
        forever begin
            @(negedge serial_line);
            repeat (cur_cbp / 2 + 1) @(negedge clk_i);
            check_value("tx_o start bit", 32'(serial_line), 32'h0);
            for (int i = 0; i < 8; i++) begin
                repeat (cur_cbp) @(negedge clk_i);
                rebuilt[i] = serial_line;
            end
            repeat (cur_cbp) @(negedge clk_i);
            check_value("tx_o stop bit 1", 32'(serial_line), 32'h1);
            if (cur_two_stop) begin
                repeat (cur_cbp) @(negedge clk_i);
                check_value("tx_o stop bit 2", 32'(serial_line), 32'h1);
            end
            check_value("tx_o byte", 32'(rebuilt), 32'(cur_byte));
            frames_seen++;
        end
    end

    initial begin : watchdog
        int limit;
        limit = timeout_cycles();
        cycle_count = 0;
        while (cycle_count < limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        errors++;
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("ERRORS FOUND");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_i        = 1'b1;
        bus_write    = 1'b0;
        bus_be       = '0;
        bus_addr     = '0;
        bus_wdata    = '0;
        errors       = 0;
        checks       = 0;
        frames_seen  = 0;
        reset_done   = 1'b0;
        cur_cbp      = CBP_W'(1);
        cur_two_stop = 1'b0;
        cur_byte     = '0;
        for (int w = 0; w < NUM_WORDS; w++) begin
            exp_regs[w] = '0;
        end
        void'($urandom(6));

        repeat (10) @(negedge clk_i);
        rst_i      = 1'b0;
        reset_done = 1'b1;

        for (int w = 0; w < NUM_WORDS; w++) begin
            read_word(w, rd);
            check_value($sformatf("rdata word %0d after reset", w), rd, 32'h0);
        end
        check_value("tx_o after reset", 32'(serial_line), 32'h1);

        check_byte_enables(REG_CBP);
        check_byte_enables(REG_STOP);
        check_byte_enables(REG_TXDATA);

        // Word 2 and the unmapped words ignore writes.
        write_word(REG_RXDATA, 4'b1111, $urandom());
        for (int w = NUM_WORDS; w < 8; w++) begin
            write_word(w, 4'b1111, $urandom());
        end
        for (int w = 0; w < 8; w++) begin
            read_word(w, rd);
            if (w < NUM_WORDS) begin
                check_value($sformatf("rdata word %0d", w), rd, exp_regs[w]);
            end else begin
                check_value($sformatf("rdata word %0d", w), rd, 32'h0);
            end
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_cbp      = effective_cbp(row_cbp[r]);
            cur_two_stop = (row_stop[r] != 2'b00);
            cur_byte     = row_byte[r];
            write_word(REG_CBP, 4'b1111, 32'(row_cbp[r]));
            write_word(REG_STOP, 4'b1111, 32'(row_stop[r]));
            write_word(REG_TXDATA, 4'b1111, 32'(row_byte[r]));
            write_word(REG_CTRL, 4'b0001, 32'(1 << CTRL_TX_EN));
            wait_for_flags();
            check_value("frames seen on tx_o", frames_seen, r + 1);
            read_word(REG_RXDATA, rd);
            check_value("rdata rx byte", rd, 32'(row_byte[r]));
            read_word(REG_CTRL, rd);
            check_value("rdata ctrl", rd, 32'(1 << CTRL_RX_DONE) | 32'(1 << CTRL_TX_DONE));
            write_word(REG_CTRL, 4'b0001, 32'h0);
            read_word(REG_CTRL, rd);
            check_value("rdata ctrl after clear", rd, 32'h0);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
src/uart_pkg.sv
src/uart_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_periph.sv
sim/uart_periph_properties.sv
sim/uart_periph_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f sim.f --top-module uart_periph_tb

status=0
out=$(./obj_dir/Vuart_periph_tb) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx 'NO ERRORS'; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
